/* tb.f */
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/instrClassify.sv
hdl/alu.sv
hdl/multDiv.sv
hdl/exStallUnit.sv
hdl/exStage.sv
hdl/exTop.sv
sim/clockGen.sv
sim/exTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps --top-module exTb -f tb.f

output=$(./obj_dir/VexTb 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1

/* sim/exTb.sv */
// Execute-stage testbench: random stimulus, reference model, compare tasks and watchdog
`timescale 1ns/100ps

module exTb;
    import isaPkg::*;
    import pipePkg::*;

    localparam int multCycles = 5;
    localparam int divCycles = 10;
    localparam int periodNs = 4;
    localparam int calcCount = 300;
    localparam int mdGroups = 60;
    // Longest multiply/divide group is five operations, plus reset
    localparam int totalOps = 8 + calcCount + mdGroups * 5;

    logic clk;
    logic reset;
    logic clr;
    logic stall;
    instrT instrEx;
    instrT instrMem;
    wordT pcEx, dataRsEx, dataRtEx, regWriteDataEx, regDataMem, regDataWb;
    wordT pcMem, aluOutMem, dataRtMem, regWriteDataMem;
    regAddrT addrRsEx, addrRtEx, regWriteAddrEx, regAddrMem, regAddrWb;
    regAddrT addrRtMem, regWriteAddrMem;
    imm16T imm16Ex;
    shamtT shamtEx;
    tnewT tnewEx;
    tnewT tnewMem;

    // Reference model state
    logic [31:0] seed = 32'd39690;
    wordT modelHi, modelLo, pendHi, pendLo;
    logic pendCommit;
    int mdRemain;

    instrT calcList [19] = '{ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU, SLL, SRL, SRA,
                             ADDIU, ANDI, ORI, XORI, SLTI, LUI, LW, SW};
    instrT mdList [4] = '{MULT, MULTU, DIV, DIVU};

    clockGen #(.periodNs(periodNs), .resetCycles(5)) clockSource (.clk(clk), .reset(reset));

    exTop #(.multCycles(multCycles), .divCycles(divCycles)) DUT (.*);

    // LCG, upper bits only since the low bits have short periods
    function automatic logic [15:0] lcgNext();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[30:15];
    endfunction

    function automatic wordT randWord();
        return {lcgNext(), lcgNext()};
    endfunction

    function automatic int randBelow(input int n);
        return int'(lcgNext()) % n;
    endfunction

    function automatic regAddrT pickAddr();
        return (randBelow(8) == 0) ? regAddrT'(0) : regAddrT'(randBelow(32));
    endfunction

    // About half of the forward addresses hit a source register
    function automatic regAddrT pickForwardAddr();
        int choice;
        choice = randBelow(4);
        if (choice == 0) begin
            return addrRsEx;
        end else if (choice == 1) begin
            return addrRtEx;
        end
        return pickAddr();
    endfunction

    function automatic logic isMdOp(input instrT op);
        return op inside {MULT, MULTU, DIV, DIVU, MFHI, MFLO, MTHI, MTLO};
    endfunction

    function automatic logic isCalc(input instrT op);
        return op inside {ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU, SLL, SRL, SRA,
                          ADDIU, ANDI, ORI, XORI, SLTI, LUI};
    endfunction

    // MEM first, then WB, register 0 is never taken from a bus
    function automatic wordT forwardOperand(input regAddrT addr, input wordT dataEx);
        if (regAddrMem != '0 && regAddrMem == addr) begin
            return regDataMem;
        end
        if (regAddrWb != '0 && regAddrWb == addr) begin
            return regDataWb;
        end
        return dataEx;
    endfunction

    function automatic wordT aluModel(input instrT op, input wordT rs, input wordT rt,
                                      input imm16T imm, input shamtT sh);
        wordT sext;
        wordT zext;
        sext = {{16{imm[15]}}, imm};
        zext = {16'h0000, imm};
        case (op)
            ADDU: return rs + rt;
            SUBU: return rs - rt;
            AND: return rs & rt;
            OR: return rs | rt;
            XOR: return rs ^ rt;
            NOR: return ~(rs | rt);
            SLT: return ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
            SLTU: return (rs < rt) ? 32'd1 : 32'd0;
            SLL: return rt << sh;
            SRL: return rt >> sh;
            SRA: return wordT'($signed(rt) >>> sh);
            ANDI: return rs & zext;
            ORI: return rs | zext;
            XORI: return rs ^ zext;
            SLTI: return ($signed(rs) < $signed(sext)) ? 32'd1 : 32'd0;
            LUI: return {imm, 16'h0000};
            // Base plus offset for memory ops
            ADDIU, LW, SW: return rs + sext;
            default: return '0;
        endcase
    endfunction

    task automatic stopOnFailure();
        $display("RESULT: FAIL");
        $fatal(1, "Stopping at the first failed check");
    endtask

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            stopOnFailure();
        end
    endtask

    task automatic checkInstr(input string name, input instrT expected, input instrT actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %s (%0d), actual %s (%0d)", name,
                     expected.name(), expected, actual.name(), actual);
            stopOnFailure();
        end
    endtask

    task automatic checkAddr(input string name, input regAddrT expected, input regAddrT actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
            stopOnFailure();
        end
    endtask

    task automatic checkTnew(input string name, input tnewT expected, input tnewT actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
            stopOnFailure();
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
            stopOnFailure();
        end
    endtask

    task automatic checkOutputs(input string name, input instrT instr, input wordT pc,
                                input wordT aluOut, input logic checkAlu, input regAddrT addrRt,
                                input wordT dataRt, input regAddrT writeAddr,
                                input wordT writeData, input tnewT tnew);
        checkInstr({name, " instrMem"}, instr, instrMem);
        checkWord({name, " pcMem"}, pc, pcMem);
        if (checkAlu) begin
            checkWord({name, " aluOutMem"}, aluOut, aluOutMem);
        end
        checkAddr({name, " addrRtMem"}, addrRt, addrRtMem);
        checkWord({name, " dataRtMem"}, dataRt, dataRtMem);
        checkAddr({name, " regWriteAddrMem"}, writeAddr, regWriteAddrMem);
        checkWord({name, " regWriteDataMem"}, writeData, regWriteDataMem);
        checkTnew({name, " tnewMem"}, tnew, tnewMem);
    endtask

    // HI/LO model, pending commit first, then the issuing instruction
    task automatic advanceModel(input logic held, input wordT rs, input wordT rt);
        longint a;
        longint b;
        logic [63:0] prod;
        a = longint'($signed(rs));
        b = longint'($signed(rt));
        if (mdRemain != 0) begin
            mdRemain--;
            if (mdRemain == 0 && pendCommit) begin
                modelHi = pendHi;
                modelLo = pendLo;
            end
        end
        if (!held) begin
            case (instrEx)
                MULT: begin
                    prod = a * b;
                    {pendHi, pendLo} = prod;
                    pendCommit = 1'b1;
                    mdRemain = multCycles - 1;
                end
                MULTU: begin
                    prod = {32'h0, rs} * {32'h0, rt};
                    {pendHi, pendLo} = prod;
                    pendCommit = 1'b1;
                    mdRemain = multCycles - 1;
                end
                DIV, DIVU: begin
                    // Zero divisor leaves HI and LO alone
                    pendCommit = (rt != '0);
                    if (rt != '0 && instrEx == DIV) begin
                        pendLo = wordT'(a / b);
                        pendHi = wordT'(a % b);
                    end else if (rt != '0) begin
                        pendLo = rs / rt;
                        pendHi = rs % rt;
                    end
                    mdRemain = divCycles - 1;
                end
                MTHI: modelHi = rs;
                MTLO: modelLo = rs;
                default: ;
            endcase
        end
    endtask

    // One clock with the current inputs, stall checked before the edge
    task automatic runCycle(input string name, output logic stalled);
        wordT fwdRs;
        wordT fwdRt;
        wordT expAlu;
        wordT expWrite;
        tnewT expTnew;
        logic expStall;
        logic bubble;
        logic checkAlu;
        #1;
        fwdRs = forwardOperand(addrRsEx, dataRsEx);
        fwdRt = forwardOperand(addrRtEx, dataRtEx);
        expStall = isMdOp(instrEx) && (mdRemain != 0);
        checkBit({name, " stall"}, expStall, stall);
        bubble = clr || expStall;
        checkAlu = !isMdOp(instrEx) || instrEx == MFHI || instrEx == MFLO;
        if (instrEx == MFHI) begin
            expAlu = modelHi;
        end else if (instrEx == MFLO) begin
            expAlu = modelLo;
        end else begin
            expAlu = aluModel(instrEx, fwdRs, fwdRt, imm16Ex, shamtEx);
        end
        if (instrEx == MFHI || instrEx == MFLO || isCalc(instrEx)) begin
            expWrite = expAlu;
        end else begin
            expWrite = regWriteDataEx;
        end
        expTnew = (tnewEx == 2'd0) ? 2'd0 : tnewEx - 2'd1;
        @(posedge clk);
        advanceModel(expStall, fwdRs, fwdRt);
        @(negedge clk);
        if (bubble) begin
            checkOutputs({name, " bubble"}, NOP, '0, '0, 1'b1, '0, '0, '0, '0, '0);
        end else begin
            checkOutputs(name, instrEx, pcEx, expAlu, checkAlu, addrRtEx, fwdRt,
                         regWriteAddrEx, expWrite, expTnew);
        end
        stalled = expStall;
    endtask

    task automatic driveOp(input instrT op);
        instrEx = op;
        pcEx = randWord() & 32'hFFFF_FFFC;
        dataRsEx = randWord();
        dataRtEx = randWord();
        imm16Ex = lcgNext();
        shamtEx = shamtT'(randBelow(32));
        addrRsEx = pickAddr();
        addrRtEx = pickAddr();
        regWriteAddrEx = pickAddr();
        regWriteDataEx = randWord();
        tnewEx = tnewT'(randBelow(4));
        regAddrMem = pickForwardAddr();
        regDataMem = randWord();
        regAddrWb = pickForwardAddr();
        regDataWb = randWord();
    endtask

    // Inputs stay put until the instruction leaves EX
    task automatic issueOp(input string name);
        logic stalled;
        stalled = 1'b1;
        while (stalled) begin
            // Occasional flush, held cycles included
            clr = (randBelow(16) == 0);
            runCycle(name, stalled);
        end
    endtask

    initial begin
        clr = 1'b0;
        instrEx = NOP;
        pcEx = '0;
        dataRsEx = '0;
        dataRtEx = '0;
        imm16Ex = '0;
        shamtEx = '0;
        addrRsEx = '0;
        addrRtEx = '0;
        regWriteAddrEx = '0;
        regWriteDataEx = '0;
        tnewEx = '0;
        regAddrMem = '0;
        regDataMem = '0;
        regAddrWb = '0;
        regDataWb = '0;
        modelHi = '0;
        modelLo = '0;
        pendHi = '0;
        pendLo = '0;
        pendCommit = 1'b0;
        mdRemain = 0;

        @(negedge reset);
        @(negedge clk);
        checkOutputs("reset", NOP, '0, '0, 1'b1, '0, '0, '0, '0, '0);
        checkBit("reset stall", 1'b0, stall);

        // Calculate and memory ops through forwarding
        for (int i = 0; i < calcCount; i++) begin
            driveOp(calcList[5'(randBelow(19))]);
            issueOp("alu");
        end

        for (int g = 0; g < mdGroups; g++) begin
            if (randBelow(4) == 0) begin
                driveOp(MTHI);
                issueOp("mthi");
                driveOp(MTLO);
                issueOp("mtlo");
            end else begin
                driveOp(mdList[2'(randBelow(4))]);
                // Zero divisor through register 0, which never forwards
                if (randBelow(4) == 0) begin
                    dataRtEx = '0;
                    addrRtEx = '0;
                end
                // Signed overflow pair is left out
                if (instrEx == DIV && forwardOperand(addrRsEx, dataRsEx) == 32'h8000_0000
                        && forwardOperand(addrRtEx, dataRtEx) == 32'hFFFF_FFFF) begin
                    instrEx = DIVU;
                end
                issueOp("muldiv");
                // Independent work while the unit is busy
                repeat (randBelow(3)) begin
                    driveOp(calcList[5'(randBelow(19))]);
                    issueOp("under busy");
                end
            end
            driveOp(MFHI);
            issueOp("mfhi");
            driveOp(MFLO);
            issueOp("mflo");
        end

        $display("RESULT: PASS");
        $finish;
    end

    // Watchdog sized from the worst case per operation
    initial begin
        #(totalOps * (divCycles + 4) * periodNs);
        $display("Timeout: the operations did not finish within the cycle budget");
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* sim/clockGen.sv */
// Testbench clock and power-on reset generator
`timescale 1ns/100ps

module clockGen #(
    parameter int periodNs    = 4,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // Released after the last reset edge
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* hdl/exTop.sv */
// Execute-stage top: stall unit and execute stage
`timescale 1ns/100ps

module exTop #(
    parameter int multCycles = 5,
    parameter int divCycles  = 10
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             clr,
    input  isaPkg::instrT    instrEx,
    input  pipePkg::wordT    pcEx,
    input  pipePkg::wordT    dataRsEx,
    input  pipePkg::wordT    dataRtEx,
    input  pipePkg::imm16T   imm16Ex,
    input  pipePkg::shamtT   shamtEx,
    input  pipePkg::regAddrT addrRsEx,
    input  pipePkg::regAddrT addrRtEx,
    input  pipePkg::regAddrT regWriteAddrEx,
    input  pipePkg::wordT    regWriteDataEx,
    input  pipePkg::tnewT    tnewEx,
    input  pipePkg::regAddrT regAddrMem,
    input  pipePkg::wordT    regDataMem,
    input  pipePkg::regAddrT regAddrWb,
    input  pipePkg::wordT    regDataWb,
    output isaPkg::instrT    instrMem,
    output pipePkg::wordT    pcMem,
    output pipePkg::wordT    aluOutMem,
    output pipePkg::regAddrT addrRtMem,
    output pipePkg::wordT    dataRtMem,
    output pipePkg::regAddrT regWriteAddrMem,
    output pipePkg::wordT    regWriteDataMem,
    output pipePkg::tnewT    tnewMem,
    output logic             stall
);
    logic mdBusy;

    exStallUnit #(
        .multCycles(multCycles),
        .divCycles (divCycles)
    ) stallUnit (
        .instrEx(instrEx),
        .mdBusy (mdBusy),
        .stall  (stall)
    );

    exStage #(
        .multCycles(multCycles),
        .divCycles (divCycles)
    ) stage (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .clr            (clr),
        .instrEx        (instrEx),
        .pcEx           (pcEx),
        .dataRsEx       (dataRsEx),
        .dataRtEx       (dataRtEx),
        .imm16Ex        (imm16Ex),
        .shamtEx        (shamtEx),
        .addrRsEx       (addrRsEx),
        .addrRtEx       (addrRtEx),
        .regWriteAddrEx (regWriteAddrEx),
        .regWriteDataEx (regWriteDataEx),
        .tnewEx         (tnewEx),
        .regAddrMem     (regAddrMem),
        .regDataMem     (regDataMem),
        .regAddrWb      (regAddrWb),
        .regDataWb      (regDataWb),
        .instrMem       (instrMem),
        .pcMem          (pcMem),
        .aluOutMem      (aluOutMem),
        .addrRtMem      (addrRtMem),
        .dataRtMem      (dataRtMem),
        .regWriteAddrMem(regWriteAddrMem),
        .regWriteDataMem(regWriteDataMem),
        .tnewMem        (tnewMem),
        .mdBusy         (mdBusy)
    );

endmodule

/* hdl/exStage.sv */
// Execute stage: operand forwarding, ALU and multiply/divide, result select, EX/MEM register
`timescale 1ns/100ps

module exStage #(
    parameter int multCycles = 5,
    parameter int divCycles  = 10
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             stall,
    input  logic             clr,
    // From ID/EX
    input  isaPkg::instrT    instrEx,
    input  pipePkg::wordT    pcEx,
    input  pipePkg::wordT    dataRsEx,
    input  pipePkg::wordT    dataRtEx,
    input  pipePkg::imm16T   imm16Ex,
    input  pipePkg::shamtT   shamtEx,
    input  pipePkg::regAddrT addrRsEx,
    input  pipePkg::regAddrT addrRtEx,
    input  pipePkg::regAddrT regWriteAddrEx,
    input  pipePkg::wordT    regWriteDataEx,
    input  pipePkg::tnewT    tnewEx,
    // Forward buses
    input  pipePkg::regAddrT regAddrMem,
    input  pipePkg::wordT    regDataMem,
    input  pipePkg::regAddrT regAddrWb,
    input  pipePkg::wordT    regDataWb,
    // EX/MEM register
    output isaPkg::instrT    instrMem,
    output pipePkg::wordT    pcMem,
    output pipePkg::wordT    aluOutMem,
    output pipePkg::regAddrT addrRtMem,
    output pipePkg::wordT    dataRtMem,
    output pipePkg::regAddrT regWriteAddrMem,
    output pipePkg::wordT    regWriteDataMem,
    output pipePkg::tnewT    tnewMem,
    output logic             mdBusy
);
    import isaPkg::*;
    import pipePkg::*;

    wordT fwdRs;
    wordT fwdRt;
    wordT aluOut;
    wordT mdOut;
    wordT exOut;
    wordT regWriteData;
    tnewT tnewNext;
    funcT func;
    logic isMd;
    logic issue;

    // MEM beats WB, register 0 never forwards
    function automatic wordT fwdSelect(
        input regAddrT addr,
        input wordT    dataEx,
        input regAddrT addrMem,
        input wordT    dataMem,
        input regAddrT addrWb,
        input wordT    dataWb
    );
        if (addrMem != '0 && addrMem == addr) begin
            return dataMem;
        end else if (addrWb != '0 && addrWb == addr) begin
            return dataWb;
        end
        return dataEx;
    endfunction

    assign fwdRs = fwdSelect(addrRsEx, dataRsEx, regAddrMem, regDataMem, regAddrWb, regDataWb);
    assign fwdRt = fwdSelect(addrRtEx, dataRtEx, regAddrMem, regDataMem, regAddrWb, regDataWb);

    // A stalled instruction is held upstream and issues later
    assign issue = ~stall;

    alu calc (
        .instr (instrEx),
        .dataRs(fwdRs),
        .dataRt(fwdRt),
        .imm16 (imm16Ex),
        .shamt (shamtEx),
        .out   (aluOut)
    );

    multDiv #(
        .multCycles(multCycles),
        .divCycles (divCycles)
    ) md (
        .clk   (clk),
        .reset (reset),
        .instr (instrEx),
        .issue (issue),
        .dataRs(fwdRs),
        .dataRt(fwdRt),
        .out   (mdOut),
        .busy  (mdBusy)
    );

    instrClassify classify (
        .instr(instrEx),
        .func (func),
        .isMd (isMd)
    );

    assign exOut = isMd ? mdOut : aluOut;

    always_comb begin
        if (instrEx == MFHI || instrEx == MFLO) begin
            regWriteData = mdOut;
        end else if (func == calcR || func == calcI) begin
            regWriteData = aluOut;
        end else begin
            // Produced further down the pipe
            regWriteData = regWriteDataEx;
        end
    end

    assign tnewNext = (tnewEx != '0) ? tnewEx - 1'b1 : '0;

    // Clear, reset and stall all load an all-zero bubble
    always_ff @(posedge clk) begin
        if (reset || clr || stall) begin
            instrMem <= NOP;
            pcMem <= '0;
            aluOutMem <= '0;
            addrRtMem <= '0;
            dataRtMem <= '0;
            regWriteAddrMem <= '0;
            regWriteDataMem <= '0;
            tnewMem <= '0;
        end else begin
            instrMem <= instrEx;
            pcMem <= pcEx;
            aluOutMem <= exOut;
            addrRtMem <= addrRtEx;
            dataRtMem <= fwdRt;
            regWriteAddrMem <= regWriteAddrEx;
            regWriteDataMem <= regWriteData;
            tnewMem <= tnewNext;
        end
    end

endmodule

/* hdl/exStallUnit.sv */
// EX stall unit: holds multiply/divide-unit instructions while the unit is busy
`timescale 1ns/100ps

module exStallUnit #(
    parameter int multCycles = 5,
    parameter int divCycles  = 10
) (
    input  isaPkg::instrT instrEx,
    input  logic          mdBusy,
    output logic          stall
);
    // Busy is already high the cycle after a start when every op
    // takes two or more cycles, so busy alone covers the start case
    logic isMd;

    instrClassify classify (
        .instr(instrEx),
        .func (),
        .isMd (isMd)
    );

    // Other instructions pass freely under a busy unit
    assign stall = isMd && mdBusy;

endmodule

/* hdl/multDiv.sv */
// Multiply/divide unit: iterative timing, HI/LO registers, busy flag, move-from/move-to
`timescale 1ns/100ps

module multDiv #(
    parameter int multCycles = 5,
    parameter int divCycles  = 10
) (
    input  logic          clk,
    input  logic          reset,
    input  isaPkg::instrT instr,
    input  logic          issue,
    input  pipePkg::wordT dataRs,
    input  pipePkg::wordT dataRt,
    output pipePkg::wordT out,
    output logic          busy
);
    import isaPkg::*;
    import pipePkg::*;

    localparam int maxCycles = (multCycles > divCycles) ? multCycles : divCycles;
    localparam int cntWidth = $clog2(maxCycles);

    wordT hi;
    wordT lo;
    // Operands and operation captured at start
    wordT opA;
    wordT opB;
    instrT opInstr;
    wordT resHi;
    wordT resLo;
    logic start;
    logic divByZero;
    logic [cntWidth-1:0] cnt;

    assign start = issue && (instr inside {MULT, MULTU, DIV, DIVU});
    assign busy = (cnt != '0);
    assign divByZero = (opInstr inside {DIV, DIVU}) && (opB == '0);

    // Move-from reads straight out of the registers
    assign out = (instr == MFHI) ? hi : lo;

    always_comb begin
        case (opInstr)
            MULT: begin
                {resHi, resLo} = 64'($signed(opA)) * 64'($signed(opB));
            end
            MULTU: begin
                {resHi, resLo} = {32'b0, opA} * {32'b0, opB};
            end
            DIV: begin
                resLo = $signed(opA) / $signed(opB);
                resHi = $signed(opA) % $signed(opB);
            end
            DIVU: begin
                resLo = opA / opB;
                resHi = opA % opB;
            end
            default: begin
                resHi = hi;
                resLo = lo;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (start) begin
            opA <= dataRs;
            opB <= dataRt;
            opInstr <= instr;
        end
    end

    // Start edge counts as the first of the busy period
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
            hi <= '0;
            lo <= '0;
        end else begin
            if (start) begin
                if (instr inside {DIV, DIVU}) begin
                    cnt <= cntWidth'(divCycles - 1);
                end else begin
                    cnt <= cntWidth'(multCycles - 1);
                end
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                // Commit on the last edge, divide by zero keeps HI/LO
                if (cnt == cntWidth'(1) && !divByZero) begin
                    hi <= resHi;
                    lo <= resLo;
                end
            end
            if (issue && instr == MTHI) begin
                hi <= dataRs;
            end
            if (issue && instr == MTLO) begin
                lo <= dataRs;
            end
        end
    end

endmodule

/* hdl/alu.sv */
// ALU: arithmetic, logic, shift, compare and address add for calculate and memory ops
`timescale 1ns/100ps

module alu (
    input  isaPkg::instrT  instr,
    input  pipePkg::wordT  dataRs,
    input  pipePkg::wordT  dataRt,
    input  pipePkg::imm16T imm16,
    input  pipePkg::shamtT shamt,
    output pipePkg::wordT  out
);
    import isaPkg::*;
    import pipePkg::*;

    wordT immSext;
    wordT immZext;

    assign immSext = {{16{imm16[15]}}, imm16};
    // Logical immediates are zero-extended
    assign immZext = {16'b0, imm16};

    always_comb begin
        case (instr)
            ADDU:  out = dataRs + dataRt;
            SUBU:  out = dataRs - dataRt;
            AND:   out = dataRs & dataRt;
            OR:    out = dataRs | dataRt;
            XOR:   out = dataRs ^ dataRt;
            NOR:   out = ~(dataRs | dataRt);
            SLT:   out = {31'b0, $signed(dataRs) < $signed(dataRt)};
            SLTU:  out = {31'b0, dataRs < dataRt};
            // Shifts act on rt by the fixed shift amount
            SLL:   out = dataRt << shamt;
            SRL:   out = dataRt >> shamt;
            SRA:   out = $signed(dataRt) >>> shamt;
            ADDIU: out = dataRs + immSext;
            ANDI:  out = dataRs & immZext;
            ORI:   out = dataRs | immZext;
            XORI:  out = dataRs ^ immZext;
            SLTI:  out = {31'b0, $signed(dataRs) < $signed(immSext)};
            LUI:   out = {imm16, 16'b0};
            // Effective address for loads and stores
            LW, SW: begin
                out = dataRs + immSext;
            end
            default: begin
                out = '0;
            end
        endcase
    end

endmodule

/* hdl/instrClassify.sv */
// Instruction classifier: function class and multiply/divide-unit flag
`timescale 1ns/100ps

module instrClassify (
    input  isaPkg::instrT instr,
    output isaPkg::funcT  func,
    output logic          isMd
);
    import isaPkg::*;

    always_comb begin
        case (instr)
            ADDU, SUBU, AND, OR, XOR, NOR,
            SLT, SLTU, SLL, SRL, SRA: begin
                func = calcR;
            end
            ADDIU, ANDI, ORI, XORI, SLTI, LUI: begin
                func = calcI;
            end
            MULT, MULTU, DIV, DIVU,
            MFHI, MFLO, MTHI, MTLO: begin
                func = mdUnit;
            end
            LW: begin
                func = load;
            end
            SW: begin
                func = store;
            end
            default: begin
                func = none;
            end
        endcase
    end

    // Anything that touches HI/LO or the iterative unit
    assign isMd = (func == mdUnit);

endmodule

/* hdl/pipePkg.sv */
// Pipeline package: word, register address, immediate, shift amount and Tnew types
package pipePkg;

    localparam int wordWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int tnewWidth = 2;

    // Data word moved between stages
    typedef logic [wordWidth-1:0] wordT;

    // Register number, register 0 is hardwired to zero
    typedef logic [regAddrWidth-1:0] regAddrT;

    typedef logic [15:0] imm16T;

    typedef logic [4:0] shamtT;

    // Cycles until the result of an instruction is available
    typedef logic [tnewWidth-1:0] tnewT;

endpackage

/* hdl/isaPkg.sv */
// ISA package: instruction code enum, function-class enum and their widths
package isaPkg;

    localparam int instrWidth = 5;
    localparam int funcWidth = 3;

    // One code per supported operation, NOP must stay zero for bubbles
    typedef enum logic [instrWidth-1:0] {
        NOP = 5'd0,
        // R-type calculate
        ADDU, SUBU, AND, OR, XOR, NOR,
        SLT, SLTU, SLL, SRL, SRA,
        // I-type calculate
        ADDIU, ANDI, ORI, XORI, SLTI, LUI,
        // Multiply/divide unit
        MULT, MULTU, DIV, DIVU,
        MFHI, MFLO, MTHI, MTLO,
        // Memory
        LW, SW
    } instrT;

    // Coarse classes used for result select and hazard checks
    typedef enum logic [funcWidth-1:0] {
        calcR,
        calcI,
        mdUnit,
        load,
        store,
        none
    } funcT;

endpackage
